/* obj_pkg.sv */
// ############################
// shared widths and types for the sprite layer
// table is 102 entries of 5 bytes
// ############################
`default_nettype none

package obj_pkg;

    typedef logic [8:0]  obj_addr_t;   // object table byte address
    typedef logic [18:0] rom_addr_t;   // graphics ROM word address
    typedef logic [15:0] rom_data_t;   // 4 pixels x 4 planes
    typedef logic [7:0]  pxl_t;        // palette in [7:4], colour in [3:0]
    typedef logic [8:0]  xpos_t;       // horizontal position

    localparam int ENTRY_BYTES = 5;
    localparam int TABLE_LAST  = 505;  // last entry base address

    // one object table entry, byte 0 first
    typedef struct packed {
        logic [7:0] y;
        logic [7:0] attr;   // en, -, -, tall, hflip_n, vflip, x8, band
        logic [7:0] attr2;  // palette, upper code
        logic [7:0] id;
        logic [7:0] x;
    } obj_entry_t;

    // what the drawer needs for one sprite row
    typedef struct packed {
        logic [11:0] code;
        logic [3:0]  row;
        xpos_t       x;
        logic [3:0]  pal;
        logic        hflip;
        logic        vflip;
    } draw_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_read_y,
        st_read_attr,
        st_read_attr2,
        st_read_id,
        st_read_x,
        st_wait_draw
    } scan_state_e;

endpackage

`default_nettype wire

/* obj_table_ram.sv */
// ############################
// CPU access wins over the scanner
// ############################
`timescale 1ns/10ps
`default_nettype none

module obj_table_ram import obj_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      obj_cs,
    input  wire logic      cpu_we,
    input  wire obj_addr_t cpu_addr,
    input  wire logic [7:0] cpu_dout,
    input  wire logic      scan_rd,
    input  wire obj_addr_t scan_addr,
    output logic [7:0]     obj_dout,
    output logic [7:0]     scan_byte,
    output logic           scan_valid
);

    logic [7:0] mem [512];
    logic [7:0] rd_q;
    obj_addr_t  addr;

    assign addr = obj_cs ? cpu_addr : scan_addr; // cpu has priority

    always_ff @(posedge clk) begin
        if (obj_cs && cpu_we) begin
            mem[addr] <= cpu_dout;
        end
        rd_q <= mem[addr];
    end

    // scanner owns the data only if it got the port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= scan_rd && !obj_cs;
        end
    end

    assign obj_dout  = rd_q;
    assign scan_byte = rd_q;

endmodule

`default_nettype wire

/* obj_scan.sv */
// ############################
// one draw request in flight at a time
// scan aborts when the blank starts
// ############################
`timescale 1ns/10ps
`default_nettype none

module obj_scan import obj_pkg::*; #(
    parameter int MAX_PER_LINE = 32
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       hbl,
    input  wire logic [7:0] vpos,
    input  wire logic [7:0] scan_byte,
    input  wire logic       scan_valid,
    input  wire logic       draw_done,
    output logic            scan_rd,
    output obj_addr_t       scan_addr,
    output logic            draw_start,
    output draw_req_t       draw_req
);

    localparam int CNT_W = $clog2(MAX_PER_LINE + 1);

    scan_state_e      state;
    obj_addr_t        base;
    obj_entry_t       entry;
    logic             wait_rsp;   // request sent, result due
    logic [CNT_W-1:0] drawn;
    logic             hbl_q;
    logic             line_start;
    logic             last_entry;
    logic             got_byte;
    logic [8:0]       sum_y;
    logic             visible;
    logic [2:0]       offset;

    assign line_start = hbl_q && !hbl;
    assign last_entry = base == obj_addr_t'(TABLE_LAST);
    assign got_byte   = wait_rsp && scan_valid && !hbl;
    assign sum_y      = {1'b0, vpos} + {1'b0, entry.y};

    // attr is checked straight off the RAM
    assign visible = scan_byte[7] && (&sum_y[7:5]) && (sum_y[8] == scan_byte[0])
                     && (sum_y[4] || scan_byte[4]);

    always_comb begin
        case (state)
            st_read_attr:  offset = 3'd1;
            st_read_attr2: offset = 3'd2;
            st_read_id:    offset = 3'd3;
            st_read_x:     offset = 3'd4;
            default:       offset = 3'd0;
        endcase
    end

    assign scan_rd   = (state != st_idle) && (state != st_wait_draw) && !wait_rsp;
    assign scan_addr = base + obj_addr_t'(offset);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            base       <= '0;
            wait_rsp   <= 1'b0;
            drawn      <= '0;
            hbl_q      <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            hbl_q      <= hbl;
            draw_start <= 1'b0;
            if (line_start) begin
                state    <= st_read_y;
                base     <= '0;
                drawn    <= '0;
                wait_rsp <= 1'b0;
            end else if (hbl) begin
                state    <= st_idle;     // out of time for this line
                wait_rsp <= 1'b0;
            end else begin
                case (state)
                    st_idle: ;
                    st_wait_draw: begin
                        if (draw_done) begin
                            drawn <= drawn + 1'b1;
                            if (last_entry || drawn == CNT_W'(MAX_PER_LINE - 1)) begin
                                state <= st_idle;
                            end else begin
                                base  <= base + obj_addr_t'(ENTRY_BYTES);
                                state <= st_read_y;
                            end
                        end
                    end
                    default: begin
                        wait_rsp <= !wait_rsp; // retry if the CPU took the port
                        if (got_byte) begin
                            case (state)
                                st_read_y:     state <= st_read_attr;
                                st_read_attr: begin
                                    if (visible) begin
                                        state <= st_read_attr2;
                                    end else if (last_entry) begin
                                        state <= st_idle;
                                    end else begin
                                        base  <= base + obj_addr_t'(ENTRY_BYTES);
                                        state <= st_read_y;
                                    end
                                end
                                st_read_attr2: state <= st_read_id;
                                st_read_id:    state <= st_read_x;
                                default: begin
                                    draw_start <= 1'b1;
                                    state      <= st_wait_draw;
                                end
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (got_byte) begin
            case (state)
                st_read_y:     entry.y     <= scan_byte;
                st_read_attr:  entry.attr  <= scan_byte;
                st_read_attr2: entry.attr2 <= scan_byte;
                st_read_id:    entry.id    <= scan_byte;
                st_read_x:     entry.x     <= scan_byte;
                default: ;
            endcase
        end
    end

    // tall sprites take the next id for the lower half
    assign draw_req.code  = {entry.attr2[3:0],
                             entry.id ^ {7'd0, entry.attr[4] & sum_y[4]}};
    assign draw_req.row   = sum_y[3:0];
    assign draw_req.x     = {entry.attr[1], entry.x};
    assign draw_req.pal   = entry.attr2[7:4];
    assign draw_req.hflip = !entry.attr[3];
    assign draw_req.vflip = entry.attr[2];

    // drawer must hand back each request before the next one
    a_one_draw: assert property (@(posedge clk) disable iff (rst)
        draw_start |=> (!draw_start until_with draw_done));

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        scan_rd |-> scan_addr <= obj_addr_t'(TABLE_LAST + ENTRY_BYTES - 1));

endmodule

`default_nettype wire

/* obj_draw.sv */
// ############################
// rom_ok must be seen twice per address
// blank start drops the rest of a sprite
// ############################
`timescale 1ns/10ps
`default_nettype none

module obj_draw import obj_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      draw_start,
    input  wire draw_req_t draw_req,
    input  wire rom_data_t rom_data,
    input  wire logic      rom_ok,
    input  wire logic      hbl,
    output logic           draw_done,
    output rom_addr_t      rom_addr,
    output logic           wr_en,
    output xpos_t          wr_x,
    output pxl_t           wr_pxl
);

    draw_req_t  req;
    rom_data_t  word_q;
    logic       busy;
    logic       have;       // word_q holds pixels still to send
    logic       ok_dly;
    logic [3:0] n;          // pixel in the row
    logic [1:0] k;
    logic [3:0] col;
    logic [3:0] xoff;
    logic       accept;

    assign k      = n[1:0];
    assign col    = {word_q[{2'b11, k}], word_q[{2'b10, k}],
                     word_q[{2'b01, k}], word_q[{2'b00, k}]};
    assign xoff   = req.hflip ? 4'd15 - n : n;
    assign accept = busy && !have && ok_dly && rom_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            have      <= 1'b0;
            ok_dly    <= 1'b0;
            n         <= '0;
            draw_done <= 1'b0;
            wr_en     <= 1'b0;
            rom_addr  <= '0;
        end else begin
            draw_done <= 1'b0;
            wr_en     <= 1'b0;
            ok_dly    <= rom_ok;
            if (busy && hbl) begin
                busy      <= 1'b0;     // abandoned, still report back
                have      <= 1'b0;
                draw_done <= 1'b1;
            end else if (!busy) begin
                if (draw_start && !hbl) begin
                    busy     <= 1'b1;
                    have     <= 1'b0;
                    n        <= '0;
                    ok_dly   <= 1'b0;
                    rom_addr <= {1'b0, draw_req.code,
                                 draw_req.row ^ {4{draw_req.vflip}}, 2'd0};
                end
            end else begin
                if (accept) begin
                    have <= 1'b1;
                    if (rom_addr[1:0] != 2'd3) begin
                        rom_addr[1:0] <= rom_addr[1:0] + 2'd1; // prefetch next word
                        ok_dly        <= 1'b0;
                    end
                end
                if (have) begin
                    wr_en <= col != 4'd0;      // colour 0 is see-through
                    n     <= n + 4'd1;
                    if (k == 2'd3) begin
                        have <= 1'b0;
                    end
                    if (n == 4'd15) begin
                        busy      <= 1'b0;
                        draw_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && draw_start) begin
            req <= draw_req;
        end
        if (accept) begin
            word_q <= rom_data;
        end
        if (busy && have) begin
            wr_x   <= req.x + xpos_t'(xoff);
            wr_pxl <= {req.pal, col};
        end
    end

endmodule

`default_nettype wire

/* obj_line_buf.sv */
// ############################
// HBL must last 512+ cycles to clear a bank
// ############################
`timescale 1ns/10ps
`default_nettype none

module obj_line_buf import obj_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  hbl,
    input  wire logic  pxl_cen,
    input  wire xpos_t hpos,
    input  wire logic  wr_en,
    input  wire xpos_t wr_x,
    input  wire pxl_t  wr_pxl,
    output pxl_t       obj_pxl
);

    pxl_t       lbuf [1024];
    logic       disp_bank;   // bank being shown, the other one is drawn
    logic       hbl_q;
    xpos_t      clr_addr;
    logic [9:0] rd_addr;
    logic       rd_en;
    pxl_t       rd_data;
    logic       rd_v;
    pxl_t       pxl_q;

    // clearing wins over the drawer during the blank
    always_ff @(posedge clk) begin
        if (hbl) begin
            lbuf[{disp_bank, clr_addr}] <= '0;
        end else if (wr_en) begin
            lbuf[{!disp_bank, wr_x}] <= wr_pxl;
        end
        rd_data <= lbuf[rd_addr];
        if (pxl_cen) begin
            rd_addr <= {disp_bank, hpos};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hbl_q     <= 1'b0;
            disp_bank <= 1'b0;
            clr_addr  <= '0;
            rd_en     <= 1'b0;
            rd_v      <= 1'b0;
            pxl_q     <= '0;
        end else begin
            hbl_q <= hbl;
            if (hbl_q && !hbl) begin
                disp_bank <= !disp_bank;
            end
            clr_addr <= hbl ? clr_addr + 1'b1 : '0;
            rd_en    <= pxl_cen;
            rd_v     <= rd_en;
            if (hbl) begin
                pxl_q <= '0;
            end else if (rd_v) begin
                pxl_q <= rd_data;  // held until the next pixel
            end
        end
    end

    assign obj_pxl = hbl ? '0 : pxl_q;

    // the drawer quits within a cycle of the blank, so no pixel
    // lands in a bank after it turns into the display bank
    a_no_late_write: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !hbl || $rose(hbl));

endmodule

`default_nettype wire

/* obj_layer.sv */
// ############################
// sprite layer top, ROM is external
// ############################
`timescale 1ns/10ps
`default_nettype none

module obj_layer import obj_pkg::*; #(
    parameter int MAX_PER_LINE = 32
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       obj_cs,
    input  wire logic       cpu_we,
    input  wire obj_addr_t  cpu_addr,
    input  wire logic [7:0] cpu_dout,
    input  wire logic [7:0] vpos,
    input  wire xpos_t      hpos,
    input  wire logic       hbl,
    input  wire logic       pxl_cen,
    input  wire rom_data_t  rom_data,
    input  wire logic       rom_ok,
    output logic [7:0]      obj_dout,
    output rom_addr_t       rom_addr,
    output pxl_t            obj_pxl
);

    logic       scan_rd;
    obj_addr_t  scan_addr;
    logic [7:0] scan_byte;
    logic       scan_valid;
    logic       draw_start;
    logic       draw_done;
    draw_req_t  draw_req;
    logic       wr_en;
    xpos_t      wr_x;
    pxl_t       wr_pxl;

    obj_table_ram u_ram (
        .clk        (clk),
        .rst        (rst),
        .obj_cs     (obj_cs),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .scan_rd    (scan_rd),
        .scan_addr  (scan_addr),
        .obj_dout   (obj_dout),
        .scan_byte  (scan_byte),
        .scan_valid (scan_valid)
    );

    obj_scan #(
        .MAX_PER_LINE (MAX_PER_LINE)
    ) u_scan (
        .clk        (clk),
        .rst        (rst),
        .hbl        (hbl),
        .vpos       (vpos),
        .scan_byte  (scan_byte),
        .scan_valid (scan_valid),
        .draw_done  (draw_done),
        .scan_rd    (scan_rd),
        .scan_addr  (scan_addr),
        .draw_start (draw_start),
        .draw_req   (draw_req)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .draw_req   (draw_req),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .hbl        (hbl),
        .draw_done  (draw_done),
        .rom_addr   (rom_addr),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_pxl     (wr_pxl)
    );

    obj_line_buf u_line (
        .clk     (clk),
        .rst     (rst),
        .hbl     (hbl),
        .pxl_cen (pxl_cen),
        .hpos    (hpos),
        .wr_en   (wr_en),
        .wr_x    (wr_x),
        .wr_pxl  (wr_pxl),
        .obj_pxl (obj_pxl)
    );

endmodule

`default_nettype wire

/* tb_obj_layer.sv */
// ############################
// ROM and CPU modelled here, MAX_PER_LINE 4
// a line is 600 blank cycles then 515 active cycles
// ############################
`timescale 1ns/10ps
`default_nettype none

module tb_obj_layer import obj_pkg::*; ();

    localparam int NT         = 6;
    localparam int MAX_SPR    = 4;
    localparam int BLANK_CYC  = 600;
    localparam int ACTIVE_CYC = 515;   // 256 pixels plus pipeline tail
    localparam int TIMEOUT    = (2 * NT + 1) * (BLANK_CYC + ACTIVE_CYC) + 500;

    typedef struct packed {
        logic [7:0]       vpos;
        logic             steal;   // CPU writes at entries 90..91 during the scan
        obj_entry_t [0:5] ent;
    } test_row_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       obj_cs;
    logic       cpu_we;
    obj_addr_t  cpu_addr;
    logic [7:0] cpu_dout;
    logic [7:0] vpos;
    xpos_t      hpos;
    logic       hbl;
    logic       pxl_cen;
    rom_data_t  rom_data;
    logic       rom_ok;
    logic [7:0] obj_dout;
    rom_addr_t  rom_addr;
    pxl_t       obj_pxl;

    test_row_t  rows [NT];
    pxl_t       exp_line [256];
    integer     seed      = 32'h82c3;
    int         drop      = 0;
    rom_addr_t  last_addr = '0;
    int         cycles    = 0;
    int         test_err;
    int         n_pass    = 0;
    int         n_fail    = 0;

    obj_layer #(
        .MAX_PER_LINE (MAX_SPR)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .obj_cs   (obj_cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .vpos     (vpos),
        .hpos     (hpos),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .obj_dout (obj_dout),
        .rom_addr (rom_addr),
        .obj_pxl  (obj_pxl)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("run stopped, still going after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // fixed mix of address bits, some pixels forced clear
    function automatic rom_data_t rom_word(input rom_addr_t a);
        logic [15:0] m;
        m = a[15:0] * 16'h9e37 ^ {a[6:0], a[18:10]};
        return m & ~{4{m[7:4] & m[3:0]}};
    endfunction

    // ROM model, rom_ok low for 0..3 cycles after each new address
    always @(posedge clk) begin
        #2;
        if (rom_addr !== last_addr) begin
            last_addr = rom_addr;
            drop      = $random(seed) & 3;
        end
        rom_ok = (drop == 0);
        if (drop != 0) begin
            drop--;
        end
        rom_data = rom_word(rom_addr);
    end

    function automatic logic [7:0] entry_byte(input obj_entry_t e, input int j);
        return e[8 * (4 - j) +: 8];   // y is byte 0
    endfunction

    // expected line, entries in table order so later ones win
    task automatic build_line(input test_row_t r);
        obj_entry_t e;
        logic [8:0] s;
        logic [11:0] code;
        rom_data_t   w;
        logic [3:0]  col;
        logic [8:0]  pos;
        int          drawn;
        drawn = 0;
        for (int i = 0; i < 256; i++) begin
            exp_line[i] = '0;
        end
        for (int i = 0; i < 6; i++) begin
            e = r.ent[i];
            s = 9'(r.vpos) + 9'(e.y);
            if (e.attr[7] && &s[7:5] && s[8] == e.attr[0] && (s[4] || e.attr[4])
                    && drawn < MAX_SPR) begin
                drawn++;
                code = {e.attr2[3:0], e.id ^ {7'd0, e.attr[4] & s[4]}};
                for (int n = 0; n < 16; n++) begin
                    w   = rom_word({1'b0, code, s[3:0] ^ {4{e.attr[2]}}, 2'(n / 4)});
                    col = {w[n % 4 + 12], w[n % 4 + 8], w[n % 4 + 4], w[n % 4]};
                    pos = {e.attr[1], e.x} + 9'(e.attr[3] ? n : 15 - n); // bit 3 low flips
                    if (col != 4'd0 && pos < 9'd256) begin
                        exp_line[pos[7:0]] = {e.attr2[7:4], col};
                    end
                end
            end
        end
    endtask

    task automatic cpu_write(input obj_addr_t a, input logic [7:0] d);
        obj_cs   = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_dout = d;
    endtask

    // mode 0 clears the table, mode 1 writes and reads back a row, mode 2 idles
    task automatic blank_phase(input int mode, input test_row_t r);
        logic [7:0] want;
        for (int c = 0; c < BLANK_CYC; c++) begin
            @(posedge clk);
            #2;
            hbl     = 1'b1;
            pxl_cen = 1'b0;
            obj_cs  = 1'b0;
            cpu_we  = 1'b0;
            if (mode == 0 && c < 512) begin
                cpu_write(obj_addr_t'(c), 8'h00);
            end else if (mode == 1 && c < 30) begin
                cpu_write(obj_addr_t'(c), entry_byte(r.ent[c / 5], c % 5));
            end else if (mode == 1 && c < 90 && c % 2 == 0) begin
                obj_cs   = 1'b1;
                cpu_addr = obj_addr_t'((c - 30) / 2);
            end else if (mode == 1 && c < 90) begin
                want = entry_byte(r.ent[(c - 31) / 10], ((c - 31) / 2) % 5);
                assert (obj_dout === want) else begin
                    $display("FAILED t=%0t obj_dout addr %0d got %h expected %h",
                             $time, (c - 31) / 2, obj_dout, want);
                    test_err++;
                end
            end
        end
    endtask

    // pixel h is requested at cycle 2h+1 and shows from cycle 2h+4
    task automatic active_phase(input logic check, input logic steal);
        for (int c = 0; c < ACTIVE_CYC; c++) begin
            @(posedge clk);
            #2;
            hbl     = 1'b0;
            pxl_cen = c < 512 && c % 2 == 1;
            hpos    = xpos_t'(c / 2);
            obj_cs  = 1'b0;
            cpu_we  = 1'b0;
            // odd and even cycles both, so scanner requests get taken too
            if (steal && c >= 4 && c < 124 && c % 3 == 0) begin
                cpu_write(obj_addr_t'(450 + (c / 6) % 10), 8'($random(seed)) & 8'h7f);
            end
            if (check && c >= 4 && c % 2 == 0) begin
                assert (obj_pxl === exp_line[(c - 4) / 2]) else begin
                    $display("FAILED t=%0t obj_pxl hpos %0d got %h expected %h",
                             $time, (c - 4) / 2, obj_pxl, exp_line[(c - 4) / 2]);
                    test_err++;
                end
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        hbl      = 1'b1;
        pxl_cen  = 1'b0;
        hpos     = '0;
        vpos     = '0;
        obj_cs   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        // entries are {y, attr, attr2, id, x}
        rows[0] = {8'h40, 1'b0, 40'hb3_88_51_23_40, 40'h0, 40'h0,
                   40'h0, 40'h0, 40'h0};
        rows[1] = {8'h10, 1'b0, 40'he7_80_32_45_20, 40'he7_8c_32_45_60, 40'he7_84_32_45_a0,
                   40'he7_88_32_45_d0, 40'h0, 40'h0};
        rows[2] = {8'h80, 1'b0, 40'h75_08_21_10_60, 40'h10_88_21_11_70, 40'h75_89_21_12_80,
                   40'h75_98_43_14_10, 40'h65_98_43_16_30, 40'h75_88_64_18_18};
        rows[3] = {8'h20, 1'b0, 40'hd8_88_15_30_50, 40'hd8_80_26_31_58, 40'hd8_8c_37_32_54,
                   40'hd8_8a_48_33_20, 40'hd8_88_59_34_f8, 40'h0};
        rows[4] = {8'h00, 1'b0, 40'hf2_88_11_40_00, 40'hf2_88_22_41_28, 40'hf2_88_33_42_50,
                   40'hf2_88_44_43_78, 40'hf2_88_55_44_a0, 40'hf2_88_66_45_c8};
        rows[5] = {8'hf8, 1'b1, 40'hfa_89_71_50_30, 40'hfa_88_72_51_50, 40'hf8_85_73_52_70,
                   40'he9_99_74_54_90, 40'h0, 40'h0};
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        blank_phase(0, rows[0]);        // whole table disabled
        active_phase(1'b0, 1'b0);
        for (int t = 0; t < NT; t++) begin
            test_err = 0;
            vpos     = rows[t].vpos;
            build_line(rows[t]);
            blank_phase(1, rows[t]);
            active_phase(1'b0, rows[t].steal);  // drawn into the back bank
            blank_phase(2, rows[t]);
            active_phase(1'b1, 1'b0);           // shown and compared
            if (test_err == 0) begin
                n_pass++;
                $display("test %0d vpos %h ok", t, rows[t].vpos);
            end else begin
                n_fail++;
                $display("test %0d vpos %h failed, %0d mismatches", t, rows[t].vpos, test_err);
            end
        end
        $display("tests passed %0d, tests failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* obj_layer.f */
obj_pkg.sv
obj_table_ram.sv
obj_scan.sv
obj_draw.sv
obj_line_buf.sv
obj_layer.sv
tb_obj_layer.sv
